/* source/seq_pkg.sv */
// rv32 sequencer definitions
package seq_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [1:0]  priv_t;

    typedef enum logic [3:0] {
        cls_load, cls_store, cls_alu_reg, cls_alu_imm, cls_jal, cls_jalr, cls_branch,
        cls_lui, cls_auipc, cls_fence, cls_mret, cls_ecall, cls_nop, cls_illegal
    } instr_class_t;

    typedef enum logic [4:0] {
        st_fetch, st_decode, st_mem_addr, st_mem_read, st_mem_wb, st_mem_write,
        st_exec_r, st_exec_i, st_alu_wb, st_jal_s, st_jalr_s, st_branch_s,
        st_lui_s, st_auipc_s, st_mret0, st_mret1, st_trap0, st_trap1
    } state_t;

    typedef enum logic [2:0] {
        trap_none, trap_irq, trap_illegal, trap_ecall, trap_load_misaligned,
        trap_store_misaligned, trap_load_fault, trap_store_fault
    } trap_kind_t;

    typedef enum logic [1:0] {src_a_pc, src_a_old_pc, src_a_rs1_buf} alu_src_a_t;
    typedef enum logic [1:0] {src_b_rs2_buf, src_b_imm_ext, src_b_const_4} alu_src_b_t;
    typedef enum logic [2:0] {
        alu_add, alu_arith_logic, alu_branch, alu_lui, alu_auipc
    } alu_op_t;
    typedef enum logic [1:0] {res_alu_out, res_data, res_alu_result} result_src_t;
    typedef enum logic [2:0] {imm_r, imm_i, imm_s, imm_b, imm_u, imm_j} imm_src_t;

    // major opcodes
    localparam opcode_t opc_load    = 7'b000_0011;
    localparam opcode_t opc_store   = 7'b010_0011;
    localparam opcode_t opc_alu_reg = 7'b011_0011;
    localparam opcode_t opc_alu_imm = 7'b001_0011;
    localparam opcode_t opc_jal     = 7'b110_1111;
    localparam opcode_t opc_jalr    = 7'b110_0111;
    localparam opcode_t opc_branch  = 7'b110_0011;
    localparam opcode_t opc_lui     = 7'b011_0111;
    localparam opcode_t opc_auipc   = 7'b001_0111;
    localparam opcode_t opc_fence   = 7'b000_1111;
    localparam opcode_t opc_system  = 7'b111_0011;

    localparam funct3_t  funct3_priv  = 3'b000;  // ecall, mret
    localparam funct7_t  funct7_ecall = 7'b000_0000;
    localparam funct7_t  funct7_mret  = 7'b001_1000;
    localparam funct7_t  funct7_alt   = 7'b010_0000;  // sub, sra
    localparam reg_idx_t rs2_ecall    = 5'b00000;
    localparam reg_idx_t rs2_mret     = 5'b00010;

    localparam xlen_t cause_illegal          = 32'd2;
    localparam xlen_t cause_load_misaligned  = 32'd4;
    localparam xlen_t cause_load_fault       = 32'd5;
    localparam xlen_t cause_store_misaligned = 32'd6;
    localparam xlen_t cause_store_fault      = 32'd7;
    localparam xlen_t cause_ecall_base       = 32'd8;  // plus privilege mode
    localparam xlen_t cause_msi              = 32'h8000_0003;
    localparam xlen_t cause_mti              = 32'h8000_0007;

    localparam int unsigned mstatus_mie_bit = 3;
    localparam int unsigned mip_msip_bit    = 3;
    localparam int unsigned mip_mtip_bit    = 7;

endpackage

/* source/instr_decode.sv */
// instruction classifier
`timescale 1ns/10ps

module instr_decode import seq_pkg::*; (
    input  opcode_t      op,
    input  funct3_t      funct3,
    input  funct7_t      funct7,
    input  reg_idx_t     rs1,
    input  reg_idx_t     rs2,
    input  reg_idx_t     rd,
    output instr_class_t instr_class,
    output imm_src_t     imm_src
);
    logic sys_base;  // funct3 and both register fields zero
    logic is_ecall;
    logic is_mret;
    logic alu_reg_ok;

    assign sys_base = (funct3 == funct3_priv) && (rs1 == '0) && (rd == '0);
    assign is_ecall = sys_base && (funct7 == funct7_ecall) && (rs2 == rs2_ecall);
    assign is_mret  = sys_base && (funct7 == funct7_mret) && (rs2 == rs2_mret);

    // only add/sub and srl/sra use the alternate funct7
    assign alu_reg_ok = (funct7 == '0) ||
                        ((funct7 == funct7_alt) && (funct3 == 3'd0 || funct3 == 3'd5));

    always_comb begin
        case (op)
            opc_load:    instr_class = (funct3 == 3'd3 || funct3[2:1] == 2'b11) ?
                                       cls_illegal : cls_load;
            opc_store:   instr_class = (funct3[2] || funct3 == 3'd3) ? cls_illegal : cls_store;
            opc_alu_reg: instr_class = alu_reg_ok ? cls_alu_reg : cls_illegal;
            opc_alu_imm: instr_class = cls_alu_imm;
            opc_jal:     instr_class = cls_jal;
            opc_jalr:    instr_class = (funct3 == 3'd0) ? cls_jalr : cls_illegal;
            opc_branch:  instr_class = (funct3[2:1] == 2'b01) ? cls_illegal : cls_branch;
            opc_lui:     instr_class = cls_lui;
            opc_auipc:   instr_class = cls_auipc;
            opc_fence:   instr_class = cls_fence;
            opc_system:  instr_class = is_ecall ? cls_ecall : (is_mret ? cls_mret : cls_illegal);
            7'b000_0000: instr_class = cls_nop;
            default:     instr_class = cls_illegal;
        endcase
    end

    always_comb begin
        case (instr_class)
            cls_alu_reg:          imm_src = imm_r;
            cls_store:            imm_src = imm_s;
            cls_branch:           imm_src = imm_b;
            cls_lui, cls_auipc:   imm_src = imm_u;
            cls_jal:              imm_src = imm_j;
            default:              imm_src = imm_i;  // loads, alu imm, jalr
        endcase
    end

endmodule

/* source/trap_unit.sv */
// trap cause and interrupt logic
`timescale 1ns/10ps

module trap_unit import seq_pkg::*; (
    input  trap_kind_t trap_kind,
    input  priv_t      privilege_mode,
    input  xlen_t      mie,
    input  xlen_t      mip,
    input  xlen_t      mstatus,
    output logic       irq_pending,
    output logic       exception_event,
    output xlen_t      cause,
    output xlen_t      badaddr
);
    logic mtip_on;
    logic msip_on;

    // enable bits in mie share the mip positions
    assign mtip_on = mstatus[mstatus_mie_bit] & mip[mip_mtip_bit] & mie[mip_mtip_bit];
    assign msip_on = mstatus[mstatus_mie_bit] & mip[mip_msip_bit] & mie[mip_msip_bit];

    assign irq_pending     = mtip_on | msip_on;
    assign exception_event = (trap_kind != trap_none);

    always_comb begin
        cause   = '0;
        badaddr = '1;  // no real faulting address here
        case (trap_kind)
            trap_irq: begin
                cause   = mtip_on ? cause_mti : cause_msi;  // timer first
                badaddr = '0;
            end
            trap_ecall: begin
                cause   = {cause_ecall_base[31:2], privilege_mode};
                badaddr = '0;
            end
            trap_illegal:          cause = cause_illegal;
            trap_load_misaligned:  cause = cause_load_misaligned;
            trap_store_misaligned: cause = cause_store_misaligned;
            trap_load_fault:       cause = cause_load_fault;
            trap_store_fault:      cause = cause_store_fault;
            default:               badaddr = '0;
        endcase
    end

endmodule

/* source/main_ctrl.sv */
// multicycle sequencer state machine
`timescale 1ns/10ps

module main_ctrl import seq_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  instr_class_t instr_class,
    input  logic         irq_pending,
    input  logic         mem_ready,
    input  logic         unaligned_load,
    input  logic         unaligned_store,
    input  logic         access_fault,
    output state_t       state,
    output trap_kind_t   trap_kind,
    output trap_kind_t   trap_held  // kind of the trap in progress, read in trap1
);
    state_t     next_state;
    trap_kind_t next_kind;
    trap_kind_t kind_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= st_fetch;
            kind_q <= trap_none;
        end else begin
            state <= next_state;
            if (next_state == st_trap0)
                kind_q <= next_kind;  // trap0 is only entered from decode or mem_addr
        end
    end

    always_comb begin
        next_state = st_fetch;
        next_kind  = trap_none;
        case (state)
            st_fetch:    next_state = mem_ready ? st_decode : st_fetch;
            st_decode: begin
                if (irq_pending) begin  // interrupt beats the instruction
                    next_state = st_trap0;
                    next_kind  = trap_irq;
                end else begin
                    case (instr_class)
                        cls_load, cls_store: next_state = st_mem_addr;
                        cls_alu_reg:         next_state = st_exec_r;
                        cls_alu_imm:         next_state = st_exec_i;
                        cls_jal:             next_state = st_jal_s;
                        cls_jalr:            next_state = st_jalr_s;
                        cls_branch:          next_state = st_branch_s;
                        cls_lui:             next_state = st_lui_s;
                        cls_auipc:           next_state = st_auipc_s;
                        cls_mret:            next_state = st_mret0;
                        cls_fence, cls_nop:  next_state = st_fetch;
                        cls_ecall: begin
                            next_state = st_trap0;
                            next_kind  = trap_ecall;
                        end
                        default: begin
                            next_state = st_trap0;
                            next_kind  = trap_illegal;
                        end
                    endcase
                end
            end
            st_mem_addr: begin
                // access fault outranks misalignment
                if (instr_class == cls_store) begin
                    next_kind  = access_fault ? trap_store_fault :
                                 (unaligned_store ? trap_store_misaligned : trap_none);
                    next_state = (next_kind == trap_none) ? st_mem_write : st_trap0;
                end else begin
                    next_kind  = access_fault ? trap_load_fault :
                                 (unaligned_load ? trap_load_misaligned : trap_none);
                    next_state = (next_kind == trap_none) ? st_mem_read : st_trap0;
                end
            end
            st_mem_read:  next_state = mem_ready ? st_mem_wb : st_mem_read;
            st_mem_write: next_state = mem_ready ? st_fetch : st_mem_write;
            st_exec_r, st_exec_i, st_lui_s, st_auipc_s, st_jal_s: next_state = st_alu_wb;
            st_jalr_s:    next_state = st_jal_s;  // target first, then link
            st_mret0:     next_state = st_mret1;
            st_trap0:     next_state = st_trap1;
            default:      next_state = st_fetch;  // mem_wb, alu_wb, branch_s, mret1, trap1
        endcase
    end

    assign trap_kind = (state == st_trap0) ? kind_q : trap_none;
    assign trap_held = kind_q;

endmodule

/* source/ctrl_outputs.sv */
// per-state datapath controls
`timescale 1ns/10ps

module ctrl_outputs import seq_pkg::*; (
    input  state_t      state,
    input  logic        mem_ready,
    input  logic        zero,
    input  trap_kind_t  trap_kind,
    output logic        adr_src,  // 0 pc, 1 alu result
    output logic        fetched_instr,
    output logic        incr_inst_retired,
    output alu_src_a_t  alu_src_a,
    output alu_src_b_t  alu_src_b,
    output alu_op_t     alu_op,
    output result_src_t result_src,
    output logic        pc_update,
    output logic        branch,
    output logic        reg_write,
    output logic        mem_write,
    output logic        mem_valid,
    output logic        alu_out_write,
    output logic        mret
);

    assign alu_out_write = !mem_valid;

    always_comb begin
        adr_src           = 1'b0;
        fetched_instr     = 1'b0;
        incr_inst_retired = 1'b0;
        alu_src_a         = src_a_pc;
        alu_src_b         = src_b_rs2_buf;
        alu_op            = alu_add;
        result_src        = res_alu_out;
        pc_update         = 1'b0;
        branch            = 1'b0;
        reg_write         = 1'b0;
        mem_write         = 1'b0;
        mem_valid         = 1'b0;
        mret              = 1'b0;
        case (state)
            st_fetch: begin
                // pc <- pc + 4 as the word arrives
                mem_valid     = 1'b1;
                alu_src_b     = src_b_const_4;
                result_src    = res_alu_result;
                fetched_instr = mem_ready;
                pc_update     = mem_ready;
            end
            st_decode: begin
                alu_src_a = src_a_old_pc;  // branch and jal target
                alu_src_b = src_b_imm_ext;
            end
            st_mem_addr, st_jalr_s: begin
                alu_src_a = src_a_rs1_buf;
                alu_src_b = src_b_imm_ext;
            end
            st_mem_read: begin
                mem_valid = 1'b1;
                adr_src   = 1'b1;
            end
            st_mem_wb: begin
                mem_valid         = 1'b1;
                result_src        = res_data;
                reg_write         = 1'b1;
                incr_inst_retired = 1'b1;
            end
            st_mem_write: begin
                mem_valid         = 1'b1;
                adr_src           = 1'b1;
                mem_write         = 1'b1;
                incr_inst_retired = mem_ready;
            end
            st_exec_r: begin
                alu_src_a = src_a_rs1_buf;
                alu_op    = alu_arith_logic;
            end
            st_exec_i: begin
                alu_src_a = src_a_rs1_buf;
                alu_src_b = src_b_imm_ext;
                alu_op    = alu_arith_logic;
            end
            st_alu_wb: begin
                mem_valid         = 1'b1;
                reg_write         = 1'b1;
                incr_inst_retired = 1'b1;
            end
            st_jal_s: begin
                alu_src_a = src_a_old_pc;  // link value old pc + 4
                alu_src_b = src_b_const_4;
                pc_update = 1'b1;
            end
            st_branch_s: begin
                alu_src_a         = src_a_rs1_buf;
                alu_op            = alu_branch;
                branch            = 1'b1;
                mem_valid         = zero;
                incr_inst_retired = 1'b1;
            end
            st_lui_s: begin
                alu_src_b = src_b_imm_ext;
                alu_op    = alu_lui;
            end
            st_auipc_s: begin
                alu_src_a = src_a_old_pc;
                alu_src_b = src_b_imm_ext;
                alu_op    = alu_auipc;
            end
            st_mret0: mret = 1'b1;
            st_mret1: begin
                pc_update         = 1'b1;
                incr_inst_retired = 1'b1;
            end
            st_trap1: begin
                pc_update         = 1'b1;  // jump to handler
                incr_inst_retired = (trap_kind != trap_irq);
            end
            default: ;  // trap0 reports through the trap unit
        endcase
    end

endmodule

/* source/seq_top.sv */
// rv32 control sequencer top
`timescale 1ns/10ps

module seq_top import seq_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  opcode_t     op,
    input  funct3_t     funct3,
    input  funct7_t     funct7,
    input  reg_idx_t    rs1,
    input  reg_idx_t    rs2,
    input  reg_idx_t    rd,
    input  logic        zero,
    input  logic        mem_ready,
    input  logic        unaligned_load,
    input  logic        unaligned_store,
    input  logic        access_fault,
    input  priv_t       privilege_mode,
    input  xlen_t       mie,
    input  xlen_t       mip,
    input  xlen_t       mstatus,
    output logic        adr_src,
    output logic        fetched_instr,
    output logic        incr_inst_retired,
    output alu_src_a_t  alu_src_a,
    output alu_src_b_t  alu_src_b,
    output alu_op_t     alu_op,
    output result_src_t result_src,
    output imm_src_t    imm_src,
    output logic        pc_update,
    output logic        branch,
    output logic        reg_write,
    output logic        mem_write,
    output logic        mem_valid,
    output logic        alu_out_write,
    output logic        exception_event,
    output xlen_t       cause,
    output xlen_t       badaddr,
    output logic        mret
);
    instr_class_t instr_class;
    logic         irq_pending;
    state_t       state;
    trap_kind_t   trap_kind;
    trap_kind_t   trap_held;

    instr_decode decode_i (
        .op          (op),
        .funct3      (funct3),
        .funct7      (funct7),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .instr_class (instr_class),
        .imm_src     (imm_src)
    );

    trap_unit trap_i (
        .trap_kind       (trap_kind),
        .privilege_mode  (privilege_mode),
        .mie             (mie),
        .mip             (mip),
        .mstatus         (mstatus),
        .irq_pending     (irq_pending),
        .exception_event (exception_event),
        .cause           (cause),
        .badaddr         (badaddr)
    );

    main_ctrl ctrl_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .instr_class     (instr_class),
        .irq_pending     (irq_pending),
        .mem_ready       (mem_ready),
        .unaligned_load  (unaligned_load),
        .unaligned_store (unaligned_store),
        .access_fault    (access_fault),
        .state           (state),
        .trap_kind       (trap_kind),
        .trap_held       (trap_held)
    );

    // held trap kind lets trap1 skip retire for interrupts
    ctrl_outputs outputs_i (
        .state             (state),
        .mem_ready         (mem_ready),
        .zero              (zero),
        .trap_kind         (trap_held),
        .adr_src           (adr_src),
        .fetched_instr     (fetched_instr),
        .incr_inst_retired (incr_inst_retired),
        .alu_src_a         (alu_src_a),
        .alu_src_b         (alu_src_b),
        .alu_op            (alu_op),
        .result_src        (result_src),
        .pc_update         (pc_update),
        .branch            (branch),
        .reg_write         (reg_write),
        .mem_write         (mem_write),
        .mem_valid         (mem_valid),
        .alu_out_write     (alu_out_write),
        .mret              (mret)
    );

endmodule

/* test/seq_sva.sv */
// sequencer timing assertions
`timescale 1ns/10ps

module seq_sva import seq_pkg::*; (
    input logic         clk,
    input logic         rst_n,
    input logic         mem_ready,
    input logic         zero,
    input state_t       state,
    input instr_class_t instr_class,
    input logic         irq_pending,
    input logic         adr_src,
    input logic         fetched_instr,
    input logic         incr_inst_retired,
    input alu_src_a_t   alu_src_a,
    input alu_src_b_t   alu_src_b,
    input alu_op_t      alu_op,
    input result_src_t  result_src,
    input logic         pc_update,
    input logic         branch,
    input logic         reg_write,
    input logic         mem_write,
    input logic         mem_valid,
    input logic         alu_out_write,
    input logic         exception_event,
    input logic         mret
);
    logic alu_decode;  // one-step alu classes
    logic jalr_decode;
    logic branch_decode;

    assign alu_decode = (state == st_decode) && !irq_pending &&
        (instr_class inside {cls_alu_reg, cls_alu_imm, cls_lui, cls_auipc, cls_jal});
    assign jalr_decode   = (state == st_decode) && !irq_pending && (instr_class == cls_jalr);
    assign branch_decode = (state == st_decode) && !irq_pending && (instr_class == cls_branch);

    a_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (state == st_fetch && !mem_ready) |-> !(reg_write || mem_write || pc_update ||
            exception_event || incr_inst_retired))
        else $error("strobe active while fetch waits for memory");
    a_fetch: assert property (@(posedge clk) disable iff (!rst_n)
        (state == st_fetch && mem_ready) |-> (pc_update && fetched_instr))
        else $error("fetch completed without pc_update and fetched_instr");
    a_pc_incr: assert property (@(posedge clk) disable iff (!rst_n)
        (state == st_fetch) |-> (!adr_src && alu_src_a == src_a_pc &&
            alu_src_b == src_b_const_4 && alu_op == alu_add))
        else $error("fetch does not read at pc or add 4 to it");
    a_load: assert property (@(posedge clk) disable iff (!rst_n)
        (state == st_mem_read && mem_ready) |=> (reg_write && result_src == res_data))
        else $error("load data not written one cycle after memory ready");
    a_store: assert property (@(posedge clk) disable iff (!rst_n)
        (state == st_mem_write) |-> (mem_write && incr_inst_retired == mem_ready))
        else $error("store write or retire out of step with memory ready");
    a_exec: assert property (@(posedge clk) disable iff (!rst_n)
        (state inside {st_exec_r, st_exec_i}) |-> (alu_src_a == src_a_rs1_buf &&
            alu_op == alu_arith_logic &&
            alu_src_b == ((state == st_exec_r) ? src_b_rs2_buf : src_b_imm_ext)))
        else $error("alu operands or operation wrong in execute");
    a_alu: assert property (@(posedge clk) disable iff (!rst_n)
        $past(alu_decode, 2) |-> (reg_write && !$past(reg_write)))
        else $error("alu result not written two cycles after decode");
    a_jalr: assert property (@(posedge clk) disable iff (!rst_n)
        $past(jalr_decode, 3) |-> (reg_write && !$past(reg_write) && !$past(reg_write, 2)))
        else $error("jalr link not written three cycles after decode");
    a_branch: assert property (@(posedge clk) disable iff (!rst_n)
        branch_decode |=> (branch && mem_valid == zero))
        else $error("branch strobe or mem_valid wrong after decode");
    a_branch_cmp: assert property (@(posedge clk) disable iff (!rst_n)
        branch |-> (alu_src_a == src_a_rs1_buf && alu_src_b == src_b_rs2_buf &&
            alu_op == alu_branch))
        else $error("branch does not compare rs1 with rs2");
    a_alu_out: assert property (@(posedge clk) disable iff (!rst_n)
        alu_out_write == !mem_valid)
        else $error("alu_out_write is not the inverse of mem_valid");
    a_mret: assert property (@(posedge clk) disable iff (!rst_n)
        mret |=> (pc_update && incr_inst_retired))
        else $error("mret not followed by pc update and retire");

endmodule

/* test/seq_tb.sv */
// control sequencer testbench
`timescale 1ns/10ps

module seq_tb import seq_pkg::*; ();
    localparam int num_instr  = 29;
    localparam int rst_cycles = 8;
    localparam int max_cycles = num_instr * 40 + rst_cycles;

    logic        clk, rst_n;
    opcode_t     op;
    funct3_t     funct3;
    funct7_t     funct7;
    reg_idx_t    rs1, rs2, rd;
    logic        zero, mem_ready, unaligned_load, unaligned_store, access_fault;
    priv_t       privilege_mode;
    xlen_t       mie, mip, mstatus;
    logic        adr_src, fetched_instr, incr_inst_retired, pc_update, branch;
    logic        reg_write, mem_write, mem_valid, alu_out_write, exception_event, mret;
    alu_src_a_t  alu_src_a;
    alu_src_b_t  alu_src_b;
    alu_op_t     alu_op;
    result_src_t result_src;
    imm_src_t    imm_src;
    xlen_t       cause, badaddr;

    integer seed = 32'h72112e7d;
    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;
    int     trap_seen, retired;
    logic   trap_exp = 1'b0;
    xlen_t  cause_exp, bad_exp;
    logic   fetch_req;  // instruction read from the pc

    seq_top dut_i (.*);

    bind seq_top seq_sva sva_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .mem_ready         (mem_ready),
        .zero              (zero),
        .state             (state),
        .instr_class       (instr_class),
        .irq_pending       (irq_pending),
        .adr_src           (adr_src),
        .fetched_instr     (fetched_instr),
        .incr_inst_retired (incr_inst_retired),
        .alu_src_a         (alu_src_a),
        .alu_src_b         (alu_src_b),
        .alu_op            (alu_op),
        .result_src        (result_src),
        .pc_update         (pc_update),
        .branch            (branch),
        .reg_write         (reg_write),
        .mem_write         (mem_write),
        .mem_valid         (mem_valid),
        .alu_out_write     (alu_out_write),
        .exception_event   (exception_event),
        .mret              (mret)
    );

    assign fetch_req = mem_valid && !adr_src && !reg_write && !branch;

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > max_cycles) begin
            $display("timeout: sequencer did not return to fetch within %0d cycles", cycles);
            $display("Errors found");
            $finish;
        end
    end

    // trap reports and retire pulses
    always @(posedge clk) begin
        if (rst_n && exception_event) begin
            trap_seen++;
            checks++;
            if (!trap_exp) begin
                errors++;
                $display("ERR %0t: unexpected trap with cause %h", $time, cause);
            end else if (cause !== cause_exp || badaddr !== bad_exp) begin
                errors++;
                $display("ERR %0t: cause %h badaddr %h, expected %h %h", $time, cause,
                         badaddr, cause_exp, bad_exp);
            end
        end
        if (rst_n && incr_inst_retired)
            retired++;
    end

    // immediate layout of each major opcode in the rv32 encoding
    function automatic imm_src_t imm_format(input opcode_t o);
        case (o)
            opc_alu_reg:        return imm_r;
            opc_store:          return imm_s;
            opc_branch:         return imm_b;
            opc_lui, opc_auipc: return imm_u;
            opc_jal:            return imm_j;
            default:            return imm_i;
        endcase
    endfunction

    // memory answers after 0 to 3 idle cycles
    task automatic mem_cycle();
        repeat ($unsigned($random(seed)) % 4) @(negedge clk);
        mem_ready = 1'b1;
        @(negedge clk);
        mem_ready = 1'b0;
    endtask

    task automatic expect_trap(input xlen_t c, input xlen_t b);
        trap_exp  = 1'b1;
        cause_exp = c;
        bad_exp   = b;
    endtask

    // starts in fetch, ends back in fetch
    task automatic run_instr(input opcode_t o, input funct3_t f3, input funct7_t f7,
                             input reg_idx_t r2);
        int   retire_exp;
        logic mem_op;
        op        = o;
        funct3    = f3;
        funct7    = f7;
        rs2       = r2;
        trap_seen = 0;
        retired   = 0;
        mem_op    = (o == opc_load || o == opc_store) && !trap_exp;
        if (trap_exp)
            retire_exp = cause_exp[31] ? 0 : 1;  // interrupts retire nothing
        else
            retire_exp = (o == opc_fence || o == 7'd0) ? 0 : 1;
        mem_cycle();
        if (!trap_exp) begin
            checks++;
            if (imm_src !== imm_format(o)) begin
                errors++;
                $display("ERR %0t: imm format %0d for opcode %b, expected %0d", $time,
                         imm_src, o, imm_format(o));
            end
        end
        if (mem_op) begin
            while (!adr_src) @(negedge clk);
            mem_cycle();  // data access
        end
        while (!fetch_req) @(negedge clk);
        checks++;
        if (trap_exp && trap_seen != 1) begin
            errors++;
            $display("ERR %0t: %0d traps for opcode %b, expected one", $time, trap_seen, o);
        end
        if (retired != retire_exp) begin
            errors++;
            $display("ERR %0t: %0d retires for opcode %b, expected %0d", $time, retired, o,
                     retire_exp);
        end
        trap_exp = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        op = '0;
        funct3 = '0;
        funct7 = '0;
        rs1 = '0;
        rs2 = '0;
        rd = '0;
        zero = 1'b0;
        mem_ready = 1'b0;
        unaligned_load = 1'b0;
        unaligned_store = 1'b0;
        access_fault = 1'b0;
        privilege_mode = 2'd3;
        mie = '0;
        mip = '0;
        mstatus = '0;
        repeat (rst_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        run_instr(opc_load, 3'd2, 7'd0, 5'd0);
        run_instr(opc_store, 3'd2, 7'd0, 5'd0);
        run_instr(opc_alu_reg, 3'd0, 7'd0, 5'd0);
        run_instr(opc_alu_reg, 3'd0, 7'b010_0000, 5'd0);  // sub
        run_instr(opc_alu_imm, 3'd0, 7'd0, 5'd0);
        run_instr(opc_jal, 3'd0, 7'd0, 5'd0);
        run_instr(opc_jalr, 3'd0, 7'd0, 5'd0);
        zero = 1'b1;
        run_instr(opc_branch, 3'd0, 7'd0, 5'd0);
        zero = 1'b0;
        run_instr(opc_branch, 3'd1, 7'd0, 5'd0);
        run_instr(opc_lui, 3'd0, 7'd0, 5'd0);
        run_instr(opc_auipc, 3'd0, 7'd0, 5'd0);
        run_instr(opc_fence, 3'd0, 7'd0, 5'd0);
        run_instr(7'd0, 3'd0, 7'd0, 5'd0);
        run_instr(opc_system, 3'd0, 7'b001_1000, 5'd2);  // mret

        expect_trap(32'd2, '1);
        run_instr(7'b111_1111, 3'd0, 7'd0, 5'd0);
        expect_trap(32'd2, '1);
        run_instr(opc_system, 3'd0, 7'b000_1000, 5'd5);  // wfi is not supported
        for (int p = 0; p < 4; p++) begin
            privilege_mode = priv_t'(p);
            expect_trap(32'd8 + p, '0);
            run_instr(opc_system, 3'd0, 7'd0, 5'd0);
        end

        // fault outranks misalignment
        unaligned_load = 1'b1;
        expect_trap(32'd4, '1);
        run_instr(opc_load, 3'd2, 7'd0, 5'd0);
        access_fault = 1'b1;
        expect_trap(32'd5, '1);
        run_instr(opc_load, 3'd2, 7'd0, 5'd0);
        unaligned_load = 1'b0;
        expect_trap(32'd5, '1);
        run_instr(opc_load, 3'd2, 7'd0, 5'd0);
        access_fault = 1'b0;
        unaligned_store = 1'b1;
        expect_trap(32'd6, '1);
        run_instr(opc_store, 3'd2, 7'd0, 5'd0);
        access_fault = 1'b1;
        expect_trap(32'd7, '1);
        run_instr(opc_store, 3'd2, 7'd0, 5'd0);
        unaligned_store = 1'b0;
        expect_trap(32'd7, '1);
        run_instr(opc_store, 3'd2, 7'd0, 5'd0);
        access_fault = 1'b0;

        mstatus = 32'h8;
        mie = 32'h88;  // timer and software enabled
        mip = 32'h88;
        expect_trap(32'h8000_0007, '0);
        run_instr(opc_alu_imm, 3'd0, 7'd0, 5'd0);
        mip = 32'h8;
        expect_trap(32'h8000_0003, '0);
        run_instr(opc_alu_imm, 3'd0, 7'd0, 5'd0);
        mstatus = '0;  // global enable off
        mip = 32'h88;
        run_instr(opc_alu_imm, 3'd0, 7'd0, 5'd0);
        mip = '0;

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

/* build.f */
source/seq_pkg.sv
source/instr_decode.sv
source/trap_unit.sv
source/main_ctrl.sv
source/ctrl_outputs.sv
source/seq_top.sv
test/seq_sva.sv
test/seq_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the sequencer testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timing --top-module seq_tb -f build.f -o seq_sim \
    && ./obj_dir/seq_sim | tee /dev/stderr | grep -q "No errors" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
